// File: mc_cfg_regs.sv
`timescale 1ns/1ns

module mc_cfg_regs
  import mc_pkg::*;
  (input                                mc_clk_i
  ,input                                rst_i

  ,input                                psel_i
  ,input                                penable_i
  ,input                                pwrite_i
  ,input        [apb_addr_width_gp-1:0] paddr_i
  ,input        [data_width_gp-1:0]     pwdata_i
  ,output logic [data_width_gp-1:0]     prdata_o
  ,output logic                         pready_o

  ,input                                rev_sent_i
  ,output logic [y_cord_width_gp-1:0]   my_y_o
  ,output logic [x_cord_width_gp-1:0]   base_x_o
  );

  localparam int cord_width_lp = x_cord_width_gp + y_cord_width_gp;

  logic [cord_width_lp-1:0] cord_r;
  logic [data_width_gp-1:0] count_r;
  logic                     wr_en;

  // write commits at the end of the access phase
  assign wr_en    = psel_i && penable_i && pwrite_i;
  assign pready_o = 1'b1;

  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
      cord_r <= '0;
    else if (wr_en && (paddr_i == cfg_cord_addr_gp))
      cord_r <= pwdata_i[cord_width_lp-1:0];
  end

  // completed responses, any write clears
  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
      count_r <= '0;
    else if (wr_en && (paddr_i == cfg_count_addr_gp))
      count_r <= '0;
    else if (rev_sent_i)
      count_r <= count_r + 1'b1;
  end

  always_comb
  begin
    prdata_o = '0;
    if (psel_i && !pwrite_i)
    begin
      if (paddr_i == cfg_cord_addr_gp)
        prdata_o = data_width_gp'(cord_r);
      else if (paddr_i == cfg_count_addr_gp)
        prdata_o = count_r;
    end
  end

  // base x low, row y above it
  assign base_x_o = cord_r[x_cord_width_gp-1:0];
  assign my_y_o   = cord_r[cord_width_lp-1:x_cord_width_gp];

endmodule

// File: mc_core_complex.sv
`timescale 1ns/1ns

module mc_core_complex
  import mc_pkg::*;
  #(parameter int num_tiles_p   = 4
   ,parameter int mem_els_p     = 16
   ,parameter int fifo_els_p    = 4
   ,parameter int rev_credits_p = 2
  )
  (input                                mc_clk_i
  ,input                                rst_i

  ,input                                fwd_link_v_i
  ,input  mc_fwd_pkt_s                  fwd_link_data_i
  ,output logic                         fwd_link_token_o

  ,output logic                         rev_link_v_o
  ,output mc_rev_pkt_s                  rev_link_data_o
  ,input                                rev_link_token_i

  ,input                                psel_i
  ,input                                penable_i
  ,input                                pwrite_i
  ,input        [apb_addr_width_gp-1:0] paddr_i
  ,input        [data_width_gp-1:0]     pwdata_i
  ,output logic [data_width_gp-1:0]     prdata_o
  ,output logic                         pready_o
  );

  logic [y_cord_width_gp-1:0] my_y_lo;
  logic [x_cord_width_gp-1:0] base_x_lo;
  logic                       rev_sent_lo;

  // link[0] is endpoint to tile 0, link[i+1] is tile i to tile i+1
  mc_link_if link [num_tiles_p:0] ();

  mc_link_endpoint
    #(.fifo_els_p   (fifo_els_p)
     ,.rev_credits_p(rev_credits_p)
    )
    endpoint
    (.mc_clk_i        (mc_clk_i)
    ,.rst_i           (rst_i)
    ,.fwd_link_v_i    (fwd_link_v_i)
    ,.fwd_link_data_i (fwd_link_data_i)
    ,.fwd_link_token_o(fwd_link_token_o)
    ,.rev_link_v_o    (rev_link_v_o)
    ,.rev_link_data_o (rev_link_data_o)
    ,.rev_link_token_i(rev_link_token_i)
    ,.rev_sent_o      (rev_sent_lo)
    ,.link            (link[0])
    );

  mc_cfg_regs cfg
    (.mc_clk_i  (mc_clk_i)
    ,.rst_i     (rst_i)
    ,.psel_i    (psel_i)
    ,.penable_i (penable_i)
    ,.pwrite_i  (pwrite_i)
    ,.paddr_i   (paddr_i)
    ,.pwdata_i  (pwdata_i)
    ,.prdata_o  (prdata_o)
    ,.pready_o  (pready_o)
    ,.rev_sent_i(rev_sent_lo)
    ,.my_y_o    (my_y_lo)
    ,.base_x_o  (base_x_lo)
    );

  for (genvar i = 0; i < num_tiles_p; i++)
  begin: tile
    mc_tile
      #(.mem_els_p(mem_els_p)
       ,.is_last_p(i == num_tiles_p - 1)
      )
      tile
      (.mc_clk_i(mc_clk_i)
      ,.rst_i   (rst_i)
      ,.my_x_i  (base_x_lo + x_cord_width_gp'(i))
      ,.my_y_i  (my_y_lo)
      ,.west    (link[i])
      ,.east    (link[i+1])
      );
  end

  // tie off the east edge of the last tile
  assign link[num_tiles_p].fwd_ready = 1'b0;
  assign link[num_tiles_p].rev_v     = 1'b0;
  assign link[num_tiles_p].rev_pkt   = '0;

endmodule

// File: mc_link_endpoint.sv
`timescale 1ns/1ns

module mc_link_endpoint
  import mc_pkg::*;
  #(parameter int fifo_els_p    = 4
   ,parameter int rev_credits_p = 2
  )
  (input                mc_clk_i
  ,input                rst_i

  ,input                fwd_link_v_i
  ,input  mc_fwd_pkt_s  fwd_link_data_i
  ,output logic         fwd_link_token_o

  ,output logic         rev_link_v_o
  ,output mc_rev_pkt_s  rev_link_data_o
  ,input                rev_link_token_i

  ,output logic         rev_sent_o

  ,mc_link_if.west_side link
  );

  localparam int ptr_width_lp  = (fifo_els_p > 1) ? $clog2(fifo_els_p) : 1;
  localparam int cnt_width_lp  = $clog2(fifo_els_p + 1);
  localparam int cred_width_lp = $clog2(rev_credits_p + 1);

  mc_fwd_pkt_s fifo_mem [fifo_els_p];

  logic [ptr_width_lp-1:0]  wr_ptr_r, rd_ptr_r;
  logic [cnt_width_lp-1:0]  count_r;
  logic [cred_width_lp-1:0] credits_r;
  logic                     enq, deq, send;
  logic                     rev_v_r;
  mc_rev_pkt_s              rev_pkt_r;

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(fifo_els_p - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // request fifo, a slot frees (and a token returns) on every dequeue
  assign enq = fwd_link_v_i && (count_r != cnt_width_lp'(fifo_els_p));
  assign deq = link.fwd_v && link.fwd_ready;

  assign link.fwd_v      = (count_r != '0);
  assign link.fwd_pkt    = fifo_mem[rd_ptr_r];
  assign fwd_link_token_o = deq;

  always_ff @(posedge mc_clk_i)
  begin
    if (enq)
      fifo_mem[wr_ptr_r] <= fwd_link_data_i;
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= next_ptr(wr_ptr_r);
      if (deq)
        rd_ptr_r <= next_ptr(rd_ptr_r);
      if (enq && !deq)
        count_r <= count_r + 1'b1;
      else if (!enq && deq)
        count_r <= count_r - 1'b1;
    end
  end

  // response side, credit spent when the packet is taken off the chain
  assign link.rev_ready = (credits_r != '0);
  assign send           = link.rev_v && link.rev_ready;

  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
    begin
      credits_r <= cred_width_lp'(rev_credits_p);
      rev_v_r   <= 1'b0;
    end
    else
    begin
      credits_r <= credits_r + cred_width_lp'(rev_link_token_i) - cred_width_lp'(send);
      rev_v_r   <= send;
    end
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (send)
      rev_pkt_r <= link.rev_pkt;
  end

  assign rev_link_v_o    = rev_v_r;
  assign rev_link_data_o = rev_pkt_r;
  assign rev_sent_o      = rev_v_r;

endmodule

// File: mc_link_if.sv
`timescale 1ns/1ns

// one hop between neighbours: requests go east, responses go west
interface mc_link_if
  import mc_pkg::*;
  ();

  logic        fwd_v;
  mc_fwd_pkt_s fwd_pkt;
  logic        fwd_ready;

  logic        rev_v;
  mc_rev_pkt_s rev_pkt;
  logic        rev_ready;

  // upstream end, sends requests and takes responses
  modport west_side
  (output fwd_v, fwd_pkt
  ,input  fwd_ready
  ,input  rev_v, rev_pkt
  ,output rev_ready
  );

  modport east_side
  (input  fwd_v, fwd_pkt
  ,output fwd_ready
  ,output rev_v, rev_pkt
  ,input  rev_ready
  );

endinterface

// File: mc_pkg.sv
package mc_pkg;

  // tile coordinates
  localparam int x_cord_width_gp = 4;
  localparam int y_cord_width_gp = 3;

  // payload widths
  localparam int addr_width_gp = 8;
  localparam int data_width_gp = 32;
  localparam int tag_width_gp  = 4;

  // apb register map
  localparam int apb_addr_width_gp = 8;
  localparam logic [apb_addr_width_gp-1:0] cfg_cord_addr_gp  = 8'h00;
  localparam logic [apb_addr_width_gp-1:0] cfg_count_addr_gp = 8'h04;

  typedef enum logic
  {
    mc_op_load_e  = 1'b0
   ,mc_op_store_e = 1'b1
  } mc_op_e;

  typedef enum logic
  {
    mc_status_ok_e  = 1'b0
   ,mc_status_err_e = 1'b1
  } mc_status_e;

  // request, 52 bits
  typedef struct packed
  {
    mc_op_e                     op;
    logic [x_cord_width_gp-1:0] x;
    logic [y_cord_width_gp-1:0] y;
    logic [addr_width_gp-1:0]   addr;
    logic [data_width_gp-1:0]   data;
    logic [tag_width_gp-1:0]    tag;
  } mc_fwd_pkt_s;

  // response, 38 bits
  typedef struct packed
  {
    mc_status_e                 status;
    mc_op_e                     op;
    logic [data_width_gp-1:0]   data;
    logic [tag_width_gp-1:0]    tag;
  } mc_rev_pkt_s;

endpackage

// File: mc_tile.sv
`timescale 1ns/1ns

module mc_tile
  import mc_pkg::*;
  #(parameter int mem_els_p = 16
   ,parameter bit is_last_p = 1'b0
  )
  (input                              mc_clk_i
  ,input                              rst_i
  ,input        [x_cord_width_gp-1:0] my_x_i
  ,input        [y_cord_width_gp-1:0] my_y_i

  ,mc_link_if.east_side               west
  ,mc_link_if.west_side               east
  );

  localparam int idx_width_lp = (mem_els_p > 1) ? $clog2(mem_els_p) : 1;

  logic [data_width_gp-1:0] mem_r [mem_els_p];

  logic                    y_match, is_local, route_east;
  logic                    west_fire;
  logic                    east_free, own_free, rev_free;
  logic                    grant_own, grant_east;
  logic                    own_take, east_take;
  logic [idx_width_lp-1:0] mem_idx;

  logic        fwd_v_r;
  mc_fwd_pkt_s fwd_pkt_r;
  logic        own_v_r;
  mc_rev_pkt_s own_pkt_r;
  logic        rev_v_r;
  mc_rev_pkt_s rev_pkt_r;
  logic        last_own_r;

  // dimension-order decode of the incoming request
  assign y_match    = (west.fwd_pkt.y == my_y_i);
  assign is_local   = y_match && (west.fwd_pkt.x == my_x_i);
  assign route_east = y_match && (west.fwd_pkt.x > my_x_i) && !is_last_p;
  assign mem_idx    = west.fwd_pkt.addr[idx_width_lp-1:0];

  assign east_free = !fwd_v_r || east.fwd_ready;
  assign own_free  = !own_v_r || own_take;

  assign west.fwd_ready = route_east ? east_free : own_free;
  assign west_fire      = west.fwd_v && west.fwd_ready;

  // eastbound output register
  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
      fwd_v_r <= 1'b0;
    else if (east_free)
      fwd_v_r <= west_fire && route_east;
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (east_free)
      fwd_pkt_r <= west.fwd_pkt;
  end

  assign east.fwd_v   = fwd_v_r;
  assign east.fwd_pkt = fwd_pkt_r;

  // scratchpad access, result lands in the own response register
  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < mem_els_p; i++)
        mem_r[i] <= '0;
    end
    else if (west_fire && is_local && (west.fwd_pkt.op == mc_op_store_e))
      mem_r[mem_idx] <= west.fwd_pkt.data;
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
      own_v_r <= 1'b0;
    else if (own_free)
      own_v_r <= west_fire && !route_east;
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (own_free)
    begin
      own_pkt_r.status <= is_local ? mc_status_ok_e : mc_status_err_e;
      own_pkt_r.op     <= west.fwd_pkt.op;
      own_pkt_r.tag    <= west.fwd_pkt.tag;
      if (is_local && (west.fwd_pkt.op == mc_op_load_e))
        own_pkt_r.data <= mem_r[mem_idx];
      else
        own_pkt_r.data <= '0;
    end
  end

  // round robin between own response and traffic from the east
  assign rev_free   = !rev_v_r || west.rev_ready;
  assign grant_own  = own_v_r && (!east.rev_v || !last_own_r);
  assign grant_east = east.rev_v && !grant_own;
  assign own_take   = rev_free && grant_own;
  assign east_take  = rev_free && grant_east;

  assign east.rev_ready = east_take;

  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
    begin
      rev_v_r    <= 1'b0;
      last_own_r <= 1'b0;
    end
    else if (rev_free)
    begin
      rev_v_r <= own_take || east_take;
      if (own_take || east_take)
        last_own_r <= own_take;
    end
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (rev_free)
      rev_pkt_r <= own_take ? own_pkt_r : east.rev_pkt;
  end

  assign west.rev_v   = rev_v_r;
  assign west.rev_pkt = rev_pkt_r;

endmodule

// File: project.f
mc_pkg.sv
mc_link_if.sv
mc_link_endpoint.sv
mc_tile.sv
mc_cfg_regs.sv
mc_core_complex.sv
tb_mc_core_complex.sv

// File: tb_mc_core_complex.sv
`timescale 1ns/1ns

module tb_mc_core_complex
  import mc_pkg::*;
  ();

  localparam int num_tiles_lp   = 4;
  localparam int mem_els_lp     = 16;
  localparam int fifo_els_lp    = 4;
  localparam int rev_credits_lp = 2;
  localparam int tags_lp        = 1 << tag_width_gp;

  // request counts per test size the timeout
  localparam int wr_per_tile_lp  = 4;
  localparam int rw_reqs_lp      = 2 * wr_per_tile_lp * num_tiles_lp;
  localparam int err_reqs_lp     = 4;
  localparam int stall_reqs_lp   = 6;
  localparam int overlap_reqs_lp = 8;
  localparam int total_reqs_lp   = rw_reqs_lp + err_reqs_lp + stall_reqs_lp + overlap_reqs_lp;
  localparam int timeout_lp      = 200 * total_reqs_lp;

  logic                         mc_clk_i;
  logic                         rst_i;
  logic                         fwd_link_v_i;
  mc_fwd_pkt_s                  fwd_link_data_i;
  logic                         fwd_link_token_o;
  logic                         rev_link_v_o;
  mc_rev_pkt_s                  rev_link_data_o;
  logic                         rev_link_token_i;
  logic                         psel_i;
  logic                         penable_i;
  logic                         pwrite_i;
  logic [apb_addr_width_gp-1:0] paddr_i;
  logic [data_width_gp-1:0]     pwdata_i;
  logic [data_width_gp-1:0]     prdata_o;
  logic                         pready_o;

  int seed           = 56415;
  int cycle_count    = 0;
  int fwd_tokens     = fifo_els_lp;
  int owed_tokens    = 0;
  bit release_tokens = 1'b1;
  int pending        = 0;
  int issued         = 0;
  int rsp_seen       = 0;

  logic [tag_width_gp-1:0]    next_tag = '0;
  logic                       exp_valid [tags_lp];
  mc_rev_pkt_s                exp_pkt [tags_lp];
  logic [data_width_gp-1:0]   model_mem [num_tiles_lp][mem_els_lp];
  logic [addr_width_gp-1:0]   addr_list [num_tiles_lp][wr_per_tile_lp];
  logic [x_cord_width_gp-1:0] base_x;
  logic [y_cord_width_gp-1:0] my_y;

  mc_core_complex
    #(.num_tiles_p  (num_tiles_lp)
     ,.mem_els_p    (mem_els_lp)
     ,.fifo_els_p   (fifo_els_lp)
     ,.rev_credits_p(rev_credits_lp)
    )
    mc_core_complex_i
    (.mc_clk_i        (mc_clk_i)
    ,.rst_i           (rst_i)
    ,.fwd_link_v_i    (fwd_link_v_i)
    ,.fwd_link_data_i (fwd_link_data_i)
    ,.fwd_link_token_o(fwd_link_token_o)
    ,.rev_link_v_o    (rev_link_v_o)
    ,.rev_link_data_o (rev_link_data_o)
    ,.rev_link_token_i(rev_link_token_i)
    ,.psel_i          (psel_i)
    ,.penable_i       (penable_i)
    ,.pwrite_i        (pwrite_i)
    ,.paddr_i         (paddr_i)
    ,.pwdata_i        (pwdata_i)
    ,.prdata_o        (prdata_o)
    ,.pready_o        (pready_o)
    );

  initial
  begin
    mc_clk_i = 1'b0;
    forever #4 mc_clk_i = ~mc_clk_i;
  end

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_error();
    end
  endtask

  // expected response from the routing rule
  // stores also update the model scratchpads
  function automatic mc_rev_pkt_s model_response(input mc_fwd_pkt_s req);
    mc_rev_pkt_s rsp;
    int          idx;
    idx        = int'(req.x) - int'(base_x);
    rsp.op     = req.op;
    rsp.tag    = req.tag;
    rsp.data   = '0;
    rsp.status = mc_status_err_e;
    if ((req.y == my_y) && (idx >= 0) && (idx < num_tiles_lp))
    begin
      rsp.status = mc_status_ok_e;
      if (req.op == mc_op_store_e)
        model_mem[idx][req.addr] = req.data;
      else
        rsp.data = model_mem[idx][req.addr];
    end
    return rsp;
  endfunction

  // waits on falling edges for a token and a free tag
  task automatic send_req(input mc_op_e op, input int x, input int y, input int addr,
                          input logic [31:0] data);
    mc_fwd_pkt_s req;
    while ((fwd_tokens == 0) || exp_valid[next_tag])
      @(negedge mc_clk_i);
    req.op   = op;
    req.x    = x_cord_width_gp'(x);
    req.y    = y_cord_width_gp'(y);
    req.addr = addr_width_gp'(addr);
    req.data = data;
    req.tag  = next_tag;
    exp_pkt[next_tag]   = model_response(req);
    exp_valid[next_tag] = 1'b1;
    pending++;
    issued++;
    fwd_tokens--;
    next_tag++;
    fwd_link_v_i    = 1'b1;
    fwd_link_data_i = req;
    @(negedge mc_clk_i);
    fwd_link_v_i = 1'b0;
  endtask

  task automatic apb_write(input logic [apb_addr_width_gp-1:0] addr, input logic [31:0] data);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    @(negedge mc_clk_i);
    penable_i = 1'b1;
    @(posedge mc_clk_i);
    check_value("pready_o", pready_o, 1);
    @(negedge mc_clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [apb_addr_width_gp-1:0] addr, output logic [31:0] data);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    @(negedge mc_clk_i);
    penable_i = 1'b1;
    // no wait states so data is taken at the edge ending the access phase
    @(posedge mc_clk_i);
    check_value("pready_o", pready_o, 1);
    data = prdata_o;
    @(negedge mc_clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic wait_idle();
    while ((pending != 0) || (owed_tokens != 0))
      @(negedge mc_clk_i);
  endtask

  always @(posedge mc_clk_i)
  begin
    cycle_count++;
    if (cycle_count > timeout_lp)
    begin
      $display("timeout: run went past %0d cycles", timeout_lp);
      stop_on_error();
    end
  end

  always @(posedge mc_clk_i)
  begin
    if (!rst_i && fwd_link_token_o)
    begin
      fwd_tokens++;
      if (fwd_tokens > fifo_els_lp)
      begin
        $display("more forward tokens came back than were spent at %0t ns", $time);
        stop_on_error();
      end
    end
  end

  always @(posedge mc_clk_i)
  begin: rsp_monitor
    mc_rev_pkt_s rsp;
    if (!rst_i && rev_link_v_o)
    begin
      rsp = rev_link_data_o;
      rsp_seen++;
      owed_tokens++;
      if (!exp_valid[rsp.tag])
      begin
        $display("response with tag %0d was not expected at %0t ns", rsp.tag, $time);
        stop_on_error();
      end
      else
      begin
        check_value("rev_link_data_o.status", rsp.status, exp_pkt[rsp.tag].status);
        check_value("rev_link_data_o.op", rsp.op, exp_pkt[rsp.tag].op);
        check_value("rev_link_data_o.data", rsp.data, exp_pkt[rsp.tag].data);
        exp_valid[rsp.tag] = 1'b0;
        pending--;
      end
    end
  end

  // one reverse token per falling edge while returns are enabled
  always @(negedge mc_clk_i)
  begin
    if (!rst_i && release_tokens && (owed_tokens > 0))
    begin
      rev_link_token_i = 1'b1;
      owed_tokens--;
    end
    else
      rev_link_token_i = 1'b0;
  end

  initial
  begin: main
    logic [31:0] rd;
    int          start_seen;
    int          t;
    for (int i = 0; i < tags_lp; i++)
      exp_valid[i] = 1'b0;
    for (int i = 0; i < num_tiles_lp; i++)
      for (int j = 0; j < mem_els_lp; j++)
        model_mem[i][j] = '0;
    rst_i            = 1'b1;
    fwd_link_v_i     = 1'b0;
    fwd_link_data_i  = '0;
    rev_link_token_i = 1'b0;
    psel_i           = 1'b0;
    penable_i        = 1'b0;
    pwrite_i         = 1'b0;
    paddr_i          = '0;
    pwdata_i         = '0;
    repeat (4) @(posedge mc_clk_i);
    @(negedge mc_clk_i);
    rst_i = 1'b0;
    check_value("fwd_link_token_o", fwd_link_token_o, 0);
    check_value("rev_link_v_o", rev_link_v_o, 0);

    // coordinates and counter over apb
    base_x = 4'd2;
    my_y   = 3'd5;
    apb_read(cfg_count_addr_gp, rd);
    check_value("count after reset", rd, 0);
    apb_write(cfg_cord_addr_gp, data_width_gp'({my_y, base_x}));
    apb_read(cfg_cord_addr_gp, rd);
    check_value("coordinate register", rd, data_width_gp'({my_y, base_x}));

    // stores then loads on every tile
    for (int i = 0; i < num_tiles_lp; i++)
      for (int k = 0; k < wr_per_tile_lp; k++)
      begin
        addr_list[i][k] = addr_width_gp'($unsigned($random(seed)) % mem_els_lp);
        send_req(mc_op_store_e, base_x + i, my_y, addr_list[i][k], $random(seed));
      end
    for (int i = 0; i < num_tiles_lp; i++)
      for (int k = 0; k < wr_per_tile_lp; k++)
        send_req(mc_op_load_e, base_x + i, my_y, addr_list[i][k], $random(seed));
    wait_idle();

    // misrouted requests
    send_req(mc_op_load_e, base_x, my_y + 1, 3, $random(seed));
    send_req(mc_op_store_e, base_x - 1, my_y, 5, $random(seed));
    send_req(mc_op_store_e, base_x + num_tiles_lp, my_y, 7, $random(seed));
    send_req(mc_op_store_e, base_x + 1, my_y - 1, addr_list[1][0], $random(seed));
    wait_idle();

    // back-pressure with reverse tokens held back
    @(posedge mc_clk_i);
    release_tokens = 1'b0;
    @(negedge mc_clk_i);
    start_seen = rsp_seen;
    for (int i = 0; i < stall_reqs_lp; i++)
      send_req(mc_op_load_e, base_x + (i % num_tiles_lp), my_y,
               addr_list[i % num_tiles_lp][1], $random(seed));
    repeat (10 * num_tiles_lp) @(negedge mc_clk_i);
    check_value("responses while tokens withheld", rsp_seen - start_seen, rev_credits_lp);
    @(posedge mc_clk_i);
    release_tokens = 1'b1;
    @(negedge mc_clk_i);
    wait_idle();

    // far tiles first so answers can overtake each other
    for (int i = 0; i < overlap_reqs_lp; i++)
    begin
      t = num_tiles_lp - 1 - (i % num_tiles_lp);
      send_req(mc_op_load_e, base_x + t, my_y,
               addr_list[t][(i / num_tiles_lp) % wr_per_tile_lp], $random(seed));
    end
    wait_idle();

    apb_read(cfg_count_addr_gp, rd);
    check_value("count register", rd, issued);
    apb_write(cfg_count_addr_gp, 32'h0);
    apb_read(cfg_count_addr_gp, rd);
    check_value("count after clear", rd, 0);

    $display("Test passed");
    $finish;
  end

endmodule
